// File: compile.f
src/exec_pkg.sv
src/ex_input_reg.sv
src/int_alu.sv
src/branch_unit.sv
src/ex_mem_forward.sv
src/exec_stage.sv
sim/exec_stage_properties.sv
sim/tb_exec_stage.sv

// File: sim/exec_stage_properties.sv
module exec_stage_checker import exec_pkg::*; (
    input logic        clock,
    input logic        reset,
    input ex_in_t      in_bundle,
    input logic        flush,
    input fetch_ctrl_t fetch,
    input ex_mem_t     mem_out
);

    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    ex_in_t                 past_bundle;
    logic                   past_flush;
    ex_in_t                 exp_held;
    logic [word_w-1:0]      exp_alu;
    logic [word_w-1:0]      exp_prev_res;
    logic [word_w-1:0]      exp_pc_res;
    fetch_ctrl_t            exp_fetch;
    logic [18:0]            exp_ctrl;
    logic [18:0]            got_ctrl;
    logic [dmem_addr_w-1:0] exp_rd_addr;
    logic [dmem_addr_w-1:0] exp_wr_addr;
    logic [word_w-1:0]      exp_wr_word;

    // ======================================================================
    // Reference rules
    // ======================================================================

    function automatic logic [word_w-1:0] alu_expect(input ex_in_t b);
        logic [word_w-1:0]        op2;
        logic signed [word_w-1:0] s1;
        logic [2*word_w-1:0]      prod;
        op2 = b.alu.neg_src2 ? (16'h0000 - b.src2) : b.src2;
        s1 = b.src1;
        prod = {16'h0000, b.src1} * {16'h0000, op2};
        if (b.alu.add) return b.src1 + op2;
        if (b.alu.mul) return prod[word_w-1:0];
        if (b.alu.sll) return (op2 >= word_w) ? 16'h0000 : b.src1 << op2[3:0];
        if (b.alu.srl) return (op2 >= word_w) ? 16'h0000 : b.src1 >> op2[3:0];
        if (b.alu.sra) begin
            // Amounts of 16 and up leave only copies of the sign
            if (op2 >= word_w) return {word_w{s1[word_w-1]}};
            return s1 >>> op2[3:0];
        end
        if (b.alu.and_op) return b.src1 & op2;
        if (b.alu.or_op) return b.src1 | op2;
        if (b.alu.xor_op) return b.src1 ^ op2;
        if (b.alu.pass_src2) return op2;
        return 16'h0000;
    endfunction

    function automatic logic cond_holds(input branch_ctrl_t c, input logic [word_w-1:0] v);
        return (c.branch_eq0 && v == 16'h0000) ||
               (c.branch_gt0 && !v[word_w-1] && v != 16'h0000) ||
               (c.branch_lt0 && v[word_w-1]);
    endfunction

    function automatic fetch_ctrl_t fetch_expect(input ex_in_t b,
                                                 input logic [word_w-1:0] cur,
                                                 input logic [word_w-1:0] prev);
        fetch_ctrl_t f;
        f = '0;
        if (b.branch.jump || (b.cycle_in_instr == 3'd1 && cond_holds(b.branch, prev))) begin
            f.flush_if    = 1'b1;
            f.flush_dc_ex = 1'b1;
            f.set_pc      = 1'b1;
            f.branch_pc   = cur[pmem_addr_w-1:0];
        end else if (b.cycle_in_instr == 3'd0 && cond_holds(b.branch, cur)) begin
            f.flush_if = 1'b1;
        end
        return f;
    endfunction

    // ======================================================================
    // Reference state
    // ======================================================================

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            past_bundle  <= '0;
            past_flush   <= 1'b0;
            exp_prev_res <= '0;
        end else begin
            past_bundle  <= in_bundle;
            past_flush   <= flush;
            exp_prev_res <= exp_alu;
        end
    end

    always_comb begin
        exp_held    = past_flush ? '0 : past_bundle;
        exp_alu     = alu_expect(exp_held);
        exp_pc_res  = {4'h0, exp_held.pc} + word_w'(pc_increment);
        exp_fetch   = fetch_expect(exp_held, exp_alu, exp_prev_res);
        exp_ctrl    = {exp_held.mem.load, exp_held.mem.store, exp_held.mem.write_reg,
                       exp_held.res_reg_idx, exp_held.pc};
        got_ctrl    = {mem_out.load, mem_out.store, mem_out.write_reg,
                       mem_out.res_reg_idx, mem_out.pc};
        exp_rd_addr = exp_held.mem.load ? exp_alu[dmem_addr_w-1:0] : 12'h000;
        exp_wr_addr = exp_held.mem.store ? exp_alu[dmem_addr_w-1:0] : 12'h000;
        exp_wr_word = exp_held.mem.store ? exp_held.src3 : 16'h0000;
    end

    // ======================================================================
    // Assertions
    // ======================================================================

    a_alu_res: assert property (@(posedge clock) disable iff (reset)
        (!past_flush && !exp_held.mem.incr_pc_is_res) |-> mem_out.res == exp_alu)
        else begin
            fail_count++;
            $error("Fail mem_out.res got %h expected %h", $sampled(mem_out.res), $sampled(exp_alu));
        end

    a_pc_res: assert property (@(posedge clock) disable iff (reset)
        exp_held.mem.incr_pc_is_res |-> mem_out.res == exp_pc_res)
        else begin
            fail_count++;
            $error("Fail mem_out.res got %h expected %h", $sampled(mem_out.res),
                   $sampled(exp_pc_res));
        end

    a_pass_through: assert property (@(posedge clock) disable iff (reset)
        got_ctrl == exp_ctrl)
        else begin
            fail_count++;
            $error("Fail mem_out control got %h expected %h", $sampled(got_ctrl),
                   $sampled(exp_ctrl));
        end

    a_load_addr: assert property (@(posedge clock) disable iff (reset)
        mem_out.dmem_rd_addr == exp_rd_addr)
        else begin
            fail_count++;
            $error("Fail mem_out.dmem_rd_addr got %h expected %h",
                   $sampled(mem_out.dmem_rd_addr), $sampled(exp_rd_addr));
        end

    a_store_req: assert property (@(posedge clock) disable iff (reset)
        mem_out.dmem_wr_addr == exp_wr_addr && mem_out.dmem_wr_word == exp_wr_word)
        else begin
            fail_count++;
            $error("Fail mem_out.dmem_wr_addr/dmem_wr_word got %h %h expected %h %h",
                   $sampled(mem_out.dmem_wr_addr), $sampled(mem_out.dmem_wr_word),
                   $sampled(exp_wr_addr), $sampled(exp_wr_word));
        end

    a_fetch: assert property (@(posedge clock) disable iff (reset)
        fetch == exp_fetch)
        else begin
            fail_count++;
            $error("Fail fetch got %h expected %h", $sampled(fetch), $sampled(exp_fetch));
        end

    // Squashed slot and first slot after reset are completely idle
    a_flush_idle: assert property (@(posedge clock) disable iff (reset)
        past_flush |-> (fetch == '0 && mem_out == '0))
        else begin
            fail_count++;
            $error("Fail fetch/mem_out after flush got %h %h expected zero",
                   $sampled(fetch), $sampled(mem_out));
        end

    a_reset_idle: assert property (@(posedge clock) disable iff (reset)
        $past(reset) |-> (fetch == '0 && mem_out == '0))
        else begin
            fail_count++;
            $error("Fail fetch/mem_out after reset got %h %h expected zero",
                   $sampled(fetch), $sampled(mem_out));
        end

endmodule

bind exec_stage exec_stage_checker props (.*);

// File: sim/tb_exec_stage.sv
module tb_exec_stage import exec_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    logic        clock = 1'b0;
    logic        reset;
    ex_in_t      in_bundle;
    logic        flush;
    fetch_ctrl_t fetch;
    ex_mem_t     mem_out;

    logic [31:0] lcg_state = 32'd31;
    int          cycle_count = 0;
    int          timeout_count = 0;
    int          unreached = 0;

    // Reach counters
    int op_seen[9];
    int cond_seen[3];
    int neg_seen;
    int jump_seen;
    int early_flush_seen;
    int redirect_seen;
    int load_seen;
    int store_seen;
    int incr_seen;
    int flush_seen;
    int flushed_store_seen;

    // Jump flag of the slot now in the stage
    logic jump_held;

    exec_stage dut0 (
        .clock     (clock),
        .reset     (reset),
        .in_bundle (in_bundle),
        .flush     (flush),
        .fetch     (fetch),
        .mem_out   (mem_out)
    );

    always #5 clock = ~clock;

    // ======================================================================
    // Stimulus helpers
    // ======================================================================

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic draw(output logic [15:0] v);
        lcg_state = lcg_step(lcg_state);
        v = lcg_state[31:16];
    endtask

    task automatic apply(input ex_in_t b, input logic f);
        @(posedge clock);
        in_bundle <= b;
        flush     <= f;
    endtask

    task automatic random_bundle(output ex_in_t b, output logic f);
        logic [15:0] r;
        logic [15:0] s;
        b = '0;
        draw(r);
        draw(s);
        // Mostly one-hot with the odd multi-flag or empty slot
        if (r[3:0] < 4'd12) begin
            b.alu[9 - (s % 9)] = 1'b1;
        end else if (r[3:0] < 4'd14) begin
            b.alu[9:1] = s[8:0];
        end
        b.alu.neg_src2 = (r[5:4] == 2'b00);
        if (r[9:6] == 4'd0) begin
            b.branch.jump = 1'b1;
        end else if (r[9:6] < 4'd6) begin
            b.branch[2:0] = 3'b001 << (r[7:6] % 3);
        end
        b.mem = r[13:10];
        draw(s);
        b.cycle_in_instr = (s[2:0] < 3'd6) ? cycle_w'(s[3]) : s[6:4];
        b.res_reg_idx = s[10:7];
        draw(s);
        b.pc = s[11:0];
        draw(b.src1);
        draw(s);
        // Small amounts keep shift results interesting
        b.src2 = r[14] ? {11'd0, s[4:0]} : s;
        draw(b.src3);
        draw(s);
        f = (s[2:0] == 3'd0);
    endtask

    task automatic run_directed();
        ex_in_t            b;
        logic [word_w-1:0] test_val;
        for (int i = 0; i < 9; i++) begin
            for (int n = 0; n < 2; n++) begin
                b = '0;
                b.alu[9-i] = 1'b1;
                b.alu.neg_src2 = n[0];
                b.mem.write_reg = 1'b1;
                b.src1 = 16'h9234;
                b.src2 = 16'd3;
                apply(b, 1'b0);
            end
        end
        // Shift amounts past the word width
        b = '0;
        b.alu.sra = 1'b1;
        b.src1 = 16'h8421;
        b.src2 = 16'd20;
        apply(b, 1'b0);
        b.alu = '0;
        b.alu.srl = 1'b1;
        apply(b, 1'b0);
        b = '0;
        b.branch.jump = 1'b1;
        b.alu.add = 1'b1;
        b.src1 = 16'h0100;
        b.src2 = 16'h0024;
        apply(b, 1'b0);
        // Two-cycle branch pairs taken first and then not taken
        for (int k = 0; k < 3; k++) begin
            for (int n = 0; n < 2; n++) begin
                case (k)
                    0: test_val = (n == 0) ? 16'h0000 : 16'h0007;
                    1: test_val = (n == 0) ? 16'h0005 : 16'hfff0;
                    default: test_val = (n == 0) ? 16'h8001 : 16'h0000;
                endcase
                b = '0;
                b.branch[2-k] = 1'b1;
                b.alu.pass_src2 = 1'b1;
                b.src2 = test_val;
                apply(b, 1'b0);
                b.cycle_in_instr = 3'd1;
                b.alu = '0;
                b.alu.add = 1'b1;
                b.src1 = 16'h0040;
                b.src2 = 16'h0010;
                apply(b, 1'b0);
            end
        end
        b = '0;
        b.mem.load = 1'b1;
        b.mem.write_reg = 1'b1;
        b.alu.add = 1'b1;
        b.src1 = 16'h1200;
        b.src2 = 16'h0034;
        b.res_reg_idx = 4'd5;
        apply(b, 1'b0);
        b.mem = '0;
        b.mem.store = 1'b1;
        b.src3 = 16'hbeef;
        apply(b, 1'b0);
        apply(b, 1'b1);
        b = '0;
        b.mem.incr_pc_is_res = 1'b1;
        b.mem.write_reg = 1'b1;
        b.pc = 12'hffe;
        b.alu.pass_src2 = 1'b1;
        b.src2 = 16'h1234;
        apply(b, 1'b0);
    endtask

    task automatic require(input int count, input string what);
        if (count == 0) begin
            $display("Error: %s was never exercised", what);
            unreached++;
        end
    endtask

    task automatic summary(input int assert_fails);
        $display("Assertion failures: %0d, unreached behaviors: %0d, timeouts: %0d",
                 assert_fails, unreached, timeout_count);
    endtask

    // ======================================================================
    // Reach monitor and timeout
    // ======================================================================

    always @(posedge clock) begin
        if (!reset) begin
            if (!flush) begin
                for (int j = 0; j < 9; j++) begin
                    if (in_bundle.alu[9-j] && $countones(in_bundle.alu[9:1]) == 1) begin
                        op_seen[j]++;
                    end
                end
                for (int j = 0; j < 3; j++) begin
                    if (in_bundle.branch[2-j] && in_bundle.cycle_in_instr == 3'd1) begin
                        cond_seen[j]++;
                    end
                end
                if (in_bundle.alu.neg_src2 && in_bundle.alu[9:1] != '0) neg_seen++;
                if (in_bundle.branch.jump) jump_seen++;
                if (in_bundle.mem.load) load_seen++;
                if (in_bundle.mem.store) store_seen++;
                if (in_bundle.mem.incr_pc_is_res) incr_seen++;
            end
            if (fetch.flush_if && !fetch.set_pc) early_flush_seen++;
            if (fetch.set_pc && !jump_held) redirect_seen++;
            if (flush) flush_seen++;
            if (flush && in_bundle.mem.store) flushed_store_seen++;
            jump_held = in_bundle.branch.jump && !flush;
        end else begin
            jump_held = 1'b0;
        end
    end

    // Limit covers reset, the directed sequences and 2000 random slots
    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= 2500) begin
            timeout_count = timeout_count + 1;
            $display("Error: timeout reached before tests completed");
            summary(dut0.props.fail_count);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // ======================================================================
    // Main sequence
    // ======================================================================

    initial begin
        ex_in_t b;
        logic   f;
        int     fails;
        reset = 1'b1;
        in_bundle = '0;
        flush = 1'b0;
        repeat (10) @(posedge clock);
        reset <= 1'b0;
        run_directed();
        for (int i = 0; i < 2000; i++) begin
            random_bundle(b, f);
            apply(b, f);
        end
        repeat (3) apply('0, 1'b0);
        @(negedge clock);
        for (int i = 0; i < 9; i++) begin
            require(op_seen[i], $sformatf("ALU operation %0d", i));
        end
        require(cond_seen[0], "second cycle of an eq0 branch");
        require(cond_seen[1], "second cycle of a gt0 branch");
        require(cond_seen[2], "second cycle of an lt0 branch");
        require(neg_seen, "operand negation");
        require(jump_seen, "jump");
        require(early_flush_seen, "taken branch in its first cycle");
        require(redirect_seen, "redirect in the second cycle of a taken branch");
        require(load_seen, "load");
        require(store_seen, "store");
        require(incr_seen, "pc increment result");
        require(flush_seen, "flush");
        require(flushed_store_seen, "flush of a store");
        fails = dut0.props.fail_count;
        summary(fails);
        if (fails == 0 && unreached == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: src/branch_unit.sv
module branch_unit import exec_pkg::*; (
    input  logic              clock,
    input  logic              reset,
    input  ex_in_t            held,
    input  logic [word_w-1:0] alu_res,
    output fetch_ctrl_t       fetch
);

    // ======================================================================
    // Previous result
    // ======================================================================

    logic [word_w-1:0] prev_res;
    logic              cond_now;
    logic              cond_prev;
    logic              first_cycle;
    logic              second_cycle;

    // Second branch cycle tests the value computed in the first one
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            prev_res <= '0;
        end else begin
            prev_res <= alu_res;
        end
    end

    // ======================================================================
    // Condition evaluation
    // ======================================================================

    function automatic logic branch_taken(input branch_ctrl_t   b,
                                          input logic [word_w-1:0] v);
        logic is_zero;
        logic is_neg;
        is_zero = (v == '0);
        is_neg  = v[word_w-1];
        return (b.branch_eq0 && is_zero) ||
               (b.branch_gt0 && !is_neg && !is_zero) ||
               (b.branch_lt0 && is_neg);
    endfunction

    assign first_cycle  = (held.cycle_in_instr == cycle_w'(0));
    assign second_cycle = (held.cycle_in_instr == cycle_w'(1));

    assign cond_now  = branch_taken(held.branch, alu_res);
    assign cond_prev = branch_taken(held.branch, prev_res);

    // ======================================================================
    // Fetch control
    // ======================================================================

    always_comb begin
        fetch = '0;
        if (held.branch.jump) begin
            // Target address comes straight out of the ALU
            fetch.flush_if    = 1'b1;
            fetch.flush_dc_ex = 1'b1;
            fetch.set_pc      = 1'b1;
            fetch.branch_pc   = alu_res[pmem_addr_w-1:0];
        end else if (first_cycle && cond_now) begin
            // Stop fetching past the branch, the target is not known yet
            fetch.flush_if = 1'b1;
        end else if (second_cycle && cond_prev) begin
            // Redirect now that the target has been computed
            fetch.flush_if    = 1'b1;
            fetch.flush_dc_ex = 1'b1;
            fetch.set_pc      = 1'b1;
            fetch.branch_pc   = alu_res[pmem_addr_w-1:0];
        end
    end

endmodule

// File: src/ex_input_reg.sv
module ex_input_reg import exec_pkg::*; (
    input  logic   clock,
    input  logic   reset,
    input  ex_in_t in_bundle,
    input  logic   flush,
    output ex_in_t held
);

    // ======================================================================
    // Input capture
    // ======================================================================

    ex_in_t bundle_q;
    logic   flush_q;

    // New operation every edge, no stall path
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            bundle_q <= '0;
            flush_q  <= 1'b0;
        end else begin
            bundle_q <= in_bundle;
            flush_q  <= flush;
        end
    end

    // ======================================================================
    // Squash
    // ======================================================================

    // A flushed slot becomes an all-zero idle operation, so the ALU,
    // branch and memory paths downstream all see nothing to do
    always_comb begin
        if (flush_q) begin
            held = '0;
        end else begin
            held = bundle_q;
        end
    end

endmodule

// File: src/ex_mem_forward.sv
module ex_mem_forward import exec_pkg::*; (
    input  ex_in_t            held,
    input  logic [word_w-1:0] alu_res,
    output ex_mem_t           mem_out
);

    // ======================================================================
    // Result select
    // ======================================================================

    logic [word_w-1:0] next_pc;

    // Return address for call-style operations
    assign next_pc = {{(word_w-pc_w){1'b0}}, held.pc} + word_w'(pc_increment);

    always_comb begin
        mem_out = '0;

        mem_out.load        = held.mem.load;
        mem_out.store       = held.mem.store;
        mem_out.write_reg   = held.mem.write_reg;
        mem_out.res_reg_idx = held.res_reg_idx;
        mem_out.pc          = held.pc;

        if (held.mem.incr_pc_is_res) begin
            mem_out.res = next_pc;
        end else begin
            mem_out.res = alu_res;
        end

        // ==================================================================
        // Data memory requests
        // ==================================================================

        // Address buses stay at zero unless a request is active
        if (held.mem.load) begin
            mem_out.dmem_rd_addr = alu_res[dmem_addr_w-1:0];
        end

        if (held.mem.store) begin
            mem_out.dmem_wr_addr = alu_res[dmem_addr_w-1:0];
            mem_out.dmem_wr_word = held.src3;
        end
    end

endmodule

// File: src/exec_pkg.sv
package exec_pkg;

    // ======================================================================
    // Widths
    // ======================================================================

    // Integer ALU word
    localparam int word_w      = 16;
    // Register file index
    localparam int reg_idx_w   = 4;
    // Program and data memory addressing
    localparam int pmem_addr_w = 12;
    localparam int dmem_addr_w = 12;
    localparam int pc_w        = 12;
    // Position of the current slot inside a multi-cycle instruction
    localparam int cycle_w     = 3;

    // Byte step to the next instruction
    localparam int pc_increment = 2;

    // ======================================================================
    // Control groups
    // ======================================================================

    // ALU operation flags, listed from highest to lowest priority
    typedef struct packed {
        logic add;
        logic mul;
        logic sll;
        logic srl;
        logic sra;
        logic and_op;
        logic or_op;
        logic xor_op;
        logic pass_src2;
        logic neg_src2;
    } alu_ctrl_t;

    // Jump and conditional branch requests
    typedef struct packed {
        logic jump;
        logic branch_eq0;
        logic branch_gt0;
        logic branch_lt0;
    } branch_ctrl_t;

    // Memory and writeback requests
    typedef struct packed {
        logic load;
        logic store;
        logic write_reg;
        logic incr_pc_is_res;
    } mem_ctrl_t;

    // ======================================================================
    // Stage bundles
    // ======================================================================

    // Operation as presented by decode
    typedef struct packed {
        alu_ctrl_t              alu;
        branch_ctrl_t           branch;
        mem_ctrl_t              mem;
        logic [cycle_w-1:0]     cycle_in_instr;
        logic [pc_w-1:0]        pc;
        logic [reg_idx_w-1:0]   res_reg_idx;
        logic [word_w-1:0]      src1;
        logic [word_w-1:0]      src2;
        logic [word_w-1:0]      src3;
    } ex_in_t;

    // Redirect and flush requests toward fetch
    typedef struct packed {
        logic                   flush_if;
        logic                   flush_dc_ex;
        logic                   set_pc;
        logic [pmem_addr_w-1:0] branch_pc;
    } fetch_ctrl_t;

    // Hand-off to the memory stage
    typedef struct packed {
        logic                   load;
        logic                   store;
        logic                   write_reg;
        logic [reg_idx_w-1:0]   res_reg_idx;
        logic [pc_w-1:0]        pc;
        logic [word_w-1:0]      res;
        logic [dmem_addr_w-1:0] dmem_rd_addr;
        logic [dmem_addr_w-1:0] dmem_wr_addr;
        logic [word_w-1:0]      dmem_wr_word;
    } ex_mem_t;

endpackage

// File: src/exec_stage.sv
module exec_stage import exec_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  ex_in_t      in_bundle,
    input  logic        flush,
    output fetch_ctrl_t fetch,
    output ex_mem_t     mem_out
);

    ex_in_t            held;
    logic [word_w-1:0] alu_res;

    // ======================================================================
    // Input register with flush squash
    // ======================================================================

    ex_input_reg u_input_reg (
        .clock     (clock),
        .reset     (reset),
        .in_bundle (in_bundle),
        .flush     (flush),
        .held      (held)
    );

    // ======================================================================
    // Integer ALU
    // ======================================================================

    int_alu u_alu (
        .held    (held),
        .alu_res (alu_res)
    );

    // ======================================================================
    // Jump and branch resolution
    // ======================================================================

    branch_unit u_branch (
        .clock   (clock),
        .reset   (reset),
        .held    (held),
        .alu_res (alu_res),
        .fetch   (fetch)
    );

    // Load, store and writeback toward the memory stage
    ex_mem_forward u_mem_fwd (
        .held    (held),
        .alu_res (alu_res),
        .mem_out (mem_out)
    );

endmodule

// File: src/int_alu.sv
module int_alu import exec_pkg::*; (
    input  ex_in_t            held,
    output logic [word_w-1:0] alu_res
);

    // ======================================================================
    // Operand preparation
    // ======================================================================

    logic [word_w-1:0]   op2;
    logic [2*word_w-1:0] product;
    logic [word_w-1:0]   shl_res;
    logic [word_w-1:0]   shr_res;
    logic [word_w-1:0]   sra_res;

    // Subtraction and negative immediates go through the two's complement
    always_comb begin
        if (held.alu.neg_src2) begin
            op2 = ~held.src2 + 1'b1;
        end else begin
            op2 = held.src2;
        end
    end

    // Full-width product, only the low word is kept
    assign product = held.src1 * op2;

    // Shift amount is the whole operand; 16 or more clears the word
    assign shl_res = held.src1 << op2;
    assign shr_res = held.src1 >> op2;

    // Sign fill once the amount reaches the word width
    assign sra_res = $signed(held.src1) >>> op2;

    // ======================================================================
    // Operation select
    // ======================================================================

    // First set flag wins when decode raises more than one
    always_comb begin
        if (held.alu.add) begin
            alu_res = held.src1 + op2;
        end else if (held.alu.mul) begin
            alu_res = product[word_w-1:0];
        end else if (held.alu.sll) begin
            alu_res = shl_res;
        end else if (held.alu.srl) begin
            alu_res = shr_res;
        end else if (held.alu.sra) begin
            alu_res = sra_res;
        end else if (held.alu.and_op) begin
            alu_res = held.src1 & op2;
        end else if (held.alu.or_op) begin
            alu_res = held.src1 | op2;
        end else if (held.alu.xor_op) begin
            alu_res = held.src1 ^ op2;
        end else if (held.alu.pass_src2) begin
            alu_res = op2;
        end else begin
            // Idle slot
            alu_res = '0;
        end
    end

endmodule
